/* lane_rx_pkg.sv */
`default_nettype none

package lane_rx_pkg;

  ////////////////////////////////////////
  // link geometry
  ////////////////////////////////////////
  localparam int n_lanes    = 12;         // lanes on the link
  localparam int word_w     = 160;        // deserialized lane word
  localparam int grp_w      = 32;         // pattern group width
  localparam int err_bit    = 29;         // raw bit flipped on induce_error
  localparam int fifo_depth = 16;         // beats buffered ahead of the checker
  localparam int fifo_aw    = $clog2(fifo_depth);
  localparam int cnt_w      = 32;         // per-lane counter width

  typedef logic [word_w-1:0]  lane_word_t;
  typedef logic [3:0]         lane_id_t;   // 0..11 used
  typedef logic [n_lanes-1:0] lane_mask_t; // one bit per lane
  typedef logic [cnt_w-1:0]   count_t;

  typedef struct packed {
    lane_id_t   lane;                     // source lane
    lane_word_t data;                     // bit-reversed word
  } lane_beat_t;                          // 164 bits

  ////////////////////////////////////////
  // register port
  ////////////////////////////////////////
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  localparam axil_addr_t reg_status    = 8'h00; // [0] locked, [1] clear busy
  localparam axil_addr_t reg_ctrl      = 8'h04; // write [0]=1 starts a clear
  localparam axil_addr_t reg_word_base = 8'h40; // word count, lane n at +4n
  localparam axil_addr_t reg_err_base  = 8'h80; // error count, lane n at +4n

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef enum logic {chk_run, chk_clear} chk_state_t;

  // good word: every upper group repeats the low group
  function automatic logic pattern_ok(lane_word_t w);
    logic ok;
    ok = 1'b1;
    for (int g = 1; g < word_w / grp_w; g++) begin
      if (w[g*grp_w +: grp_w] != w[grp_w-1:0]) ok = 1'b0; // group mismatch
    end
    return ok;
  endfunction

endpackage

`default_nettype wire

/* lane_word_front.sv */
`default_nettype none
`timescale 1ns/100ps

module lane_word_front (
  input  wire                     clk50,
  input  wire                     rst_n,
  input  wire                     raw_valid,
  output logic                    raw_ready,
  input  lane_rx_pkg::lane_id_t   raw_lane,
  input  lane_rx_pkg::lane_word_t raw_data,
  input  lane_rx_pkg::lane_mask_t induce_error,
  input  lane_rx_pkg::lane_mask_t gearbox_slip,
  input  lane_rx_pkg::lane_mask_t reset_done,
  output logic                    beat_valid,
  input  wire                     beat_ready,
  output lane_rx_pkg::lane_beat_t beat,
  output lane_rx_pkg::lane_mask_t slip_pulse,
  output logic                    locked
);

  logic                    up_q;          // goes high one cycle out of reset
  logic                    raw_take;      // raw beat accepted this cycle
  logic                    flip;          // error injection on this beat's lane
  lane_rx_pkg::lane_word_t err_word;      // raw word after error injection
  lane_rx_pkg::lane_word_t rev_word;      // msb-first word as the checker wants it
  lane_rx_pkg::lane_mask_t slip_q;        // previous gearbox_slip level
  lane_rx_pkg::lane_mask_t slip_edge;     // rising edges this cycle
  lane_rx_pkg::lane_mask_t edge_q;        // edges one cycle back

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////
  assign raw_ready = up_q && (!beat_valid || beat_ready); // empty or draining
  assign raw_take  = raw_valid && raw_ready;
  assign flip      = (raw_lane < lane_rx_pkg::n_lanes) && induce_error[raw_lane];

  always_comb begin
    err_word = raw_data;
    if (flip) err_word[lane_rx_pkg::err_bit] = ~raw_data[lane_rx_pkg::err_bit];
    for (int i = 0; i < lane_rx_pkg::word_w; i++) begin
      rev_word[i] = err_word[lane_rx_pkg::word_w-1-i]; // bit order swap
    end
  end

  always_ff @(posedge clk50) begin
    if (!rst_n) begin
      up_q       <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      up_q <= 1'b1;
      if (raw_take) beat_valid <= 1'b1;           // refill, possibly same cycle as drain
      else if (beat_ready) beat_valid <= 1'b0;    // drained with nothing behind it
    end
  end

  always_ff @(posedge clk50) begin
    if (raw_take) begin
      beat.lane <= raw_lane;
      beat.data <= rev_word;
    end
  end

  ////////////////////////////////////////
  // slip strobe and lock
  ////////////////////////////////////////
  assign slip_edge = gearbox_slip & ~slip_q;

  // pulse covers the two cycles after each rising edge
  always_ff @(posedge clk50) begin
    if (!rst_n) begin
      slip_q     <= '0;
      edge_q     <= '0;
      slip_pulse <= '0;
      locked     <= 1'b0;
    end else begin
      slip_q     <= gearbox_slip;
      edge_q     <= slip_edge;
      slip_pulse <= slip_edge | edge_q;
      locked     <= &reset_done;              // all lanes out of reset
    end
  end

endmodule

`default_nettype wire

/* lane_word_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module lane_word_fifo (
  input  wire                     clk50,
  input  wire                     rst_n,
  input  wire                     in_valid,
  output logic                    in_ready,
  input  lane_rx_pkg::lane_beat_t in_beat,
  output logic                    out_valid,
  input  wire                     out_ready,
  output lane_rx_pkg::lane_beat_t out_beat
);

  lane_rx_pkg::lane_beat_t          mem [lane_rx_pkg::fifo_depth]; // beat storage
  logic [lane_rx_pkg::fifo_aw-1:0]  wr_ptr;   // next slot to fill
  logic [lane_rx_pkg::fifo_aw-1:0]  rd_ptr;   // oldest beat
  logic [lane_rx_pkg::fifo_aw:0]    fill;     // beats held, 0..depth
  logic                             push;
  logic                             pop;

  assign in_ready  = (fill != (lane_rx_pkg::fifo_aw+1)'(lane_rx_pkg::fifo_depth));
  assign out_valid = (fill != '0);
  assign out_beat  = mem[rd_ptr];             // head always on the output
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk50) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;       // wraps at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;                 // both or neither
      endcase
    end
  end

  always_ff @(posedge clk50) begin
    if (push) mem[wr_ptr] <= in_beat;
  end

endmodule

`default_nettype wire

/* lane_pattern_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module lane_pattern_checker (
  input  wire                     clk50,
  input  wire                     rst_n,
  input  wire                     beat_valid,
  output logic                    beat_ready,
  input  lane_rx_pkg::lane_beat_t beat,
  input  wire                     clear_req,
  output logic                    busy,
  input  lane_rx_pkg::lane_id_t   rd_lane,
  output lane_rx_pkg::count_t     word_count,
  output lane_rx_pkg::count_t     err_count
);

  lane_rx_pkg::chk_state_t state;
  lane_rx_pkg::lane_id_t   clr_idx;          // lane being zeroed
  lane_rx_pkg::count_t     word_cnt [lane_rx_pkg::n_lanes];
  lane_rx_pkg::count_t     err_cnt  [lane_rx_pkg::n_lanes];
  logic                    acc_q;            // a beat was taken last cycle
  lane_rx_pkg::lane_id_t   lane_q;           // its lane
  logic                    bad_q;            // it broke the pattern
  logic                    take;

  assign beat_ready = (state == lane_rx_pkg::chk_run); // stalls only during a clear
  assign busy       = (state == lane_rx_pkg::chk_clear);
  assign take       = beat_valid && beat_ready;

  ////////////////////////////////////////
  // clear sweep
  ////////////////////////////////////////
  always_ff @(posedge clk50) begin
    if (!rst_n) begin
      state   <= lane_rx_pkg::chk_run;
      clr_idx <= '0;
    end else begin
      case (state)
        lane_rx_pkg::chk_run: begin
          clr_idx <= '0;
          if (clear_req) state <= lane_rx_pkg::chk_clear;
        end
        lane_rx_pkg::chk_clear: begin
          clr_idx <= clr_idx + 1'b1;           // one lane per cycle
          if (clr_idx == lane_rx_pkg::lane_id_t'(lane_rx_pkg::n_lanes - 1))
            state <= lane_rx_pkg::chk_run;     // last lane done
        end
        default: state <= lane_rx_pkg::chk_run;
      endcase
    end
  end

  ////////////////////////////////////////
  // check stage then count stage
  ////////////////////////////////////////
  always_ff @(posedge clk50) begin
    if (!rst_n) acc_q <= 1'b0;
    else        acc_q <= take;
  end

  always_ff @(posedge clk50) begin
    if (take) begin
      lane_q <= beat.lane;
      bad_q  <= !lane_rx_pkg::pattern_ok(beat.data);
    end
  end

  always_ff @(posedge clk50) begin
    if (!rst_n) begin
      for (int i = 0; i < lane_rx_pkg::n_lanes; i++) begin
        word_cnt[i] <= '0;
        err_cnt[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < lane_rx_pkg::n_lanes; i++) begin
        if (busy && clr_idx == lane_rx_pkg::lane_id_t'(i)) begin
          word_cnt[i] <= '0;                   // zero wins over a late count
          err_cnt[i]  <= '0;
        end else if (acc_q && lane_q == lane_rx_pkg::lane_id_t'(i)) begin
          word_cnt[i] <= word_cnt[i] + 1'b1;
          if (bad_q) err_cnt[i] <= err_cnt[i] + 1'b1;
        end
      end
    end
  end

  // read mux, lanes past the last one read as zero
  assign word_count = (rd_lane < lane_rx_pkg::n_lanes) ? word_cnt[rd_lane] : '0;
  assign err_count  = (rd_lane < lane_rx_pkg::n_lanes) ? err_cnt[rd_lane] : '0;

endmodule

`default_nettype wire

/* axil_lane_status.sv */
`default_nettype none
`timescale 1ns/100ps

module axil_lane_status (
  input  wire                     clk50,
  input  wire                     rst_n,
  input  wire                     awvalid,
  output logic                    awready,
  input  lane_rx_pkg::axil_addr_t awaddr,
  input  wire                     wvalid,
  output logic                    wready,
  input  lane_rx_pkg::axil_data_t wdata,
  output logic                    bvalid,
  input  wire                     bready,
  output logic [1:0]              bresp,
  input  wire                     arvalid,
  output logic                    arready,
  input  lane_rx_pkg::axil_addr_t araddr,
  output logic                    rvalid,
  input  wire                     rready,
  output lane_rx_pkg::axil_data_t rdata,
  output logic [1:0]              rresp,
  input  wire                     locked,
  input  wire                     busy,
  output logic                    clear_req,
  output lane_rx_pkg::lane_id_t   rd_lane,
  input  lane_rx_pkg::count_t     word_count,
  input  lane_rx_pkg::count_t     err_count
);

  logic                    en_q;             // channels open one cycle out of reset
  logic                    aw_hold;          // address taken, waiting for data
  logic                    w_hold;           // data taken, waiting for address
  lane_rx_pkg::axil_addr_t waddr_q;
  lane_rx_pkg::axil_data_t wdata_q;
  logic                    aw_take;
  logic                    w_take;
  logic                    ar_take;
  logic                    wr_go;            // both halves of a write present
  lane_rx_pkg::axil_addr_t wr_addr;
  lane_rx_pkg::axil_data_t wr_data;
  lane_rx_pkg::axil_data_t rd_data;
  logic [1:0]              rd_resp;

  assign awready = en_q && !aw_hold && !bvalid;
  assign wready  = en_q && !w_hold && !bvalid;
  assign arready = en_q && !rvalid;
  assign aw_take = awvalid && awready;
  assign w_take  = wvalid && wready;
  assign ar_take = arvalid && arready;
  assign wr_go   = (aw_hold || aw_take) && (w_hold || w_take) && !bvalid;
  assign wr_addr = aw_hold ? waddr_q : awaddr; // held or arriving now
  assign wr_data = w_hold ? wdata_q : wdata;
  assign bresp   = lane_rx_pkg::resp_okay;   // writes never fail
  assign rd_lane = araddr[5:2];              // lane field of both count windows

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    rd_resp = lane_rx_pkg::resp_slverr;      // unmapped unless matched below
    if (araddr == lane_rx_pkg::reg_status) begin
      rd_data[1:0] = {busy, locked};
      rd_resp      = lane_rx_pkg::resp_okay;
    end else if (araddr == lane_rx_pkg::reg_ctrl) begin
      rd_resp = lane_rx_pkg::resp_okay;      // reads back as zero
    end else if (araddr[1:0] == 2'b00 && araddr >= lane_rx_pkg::reg_word_base &&
                 araddr < lane_rx_pkg::reg_word_base + 4 * lane_rx_pkg::n_lanes) begin
      rd_data = word_count;
      rd_resp = lane_rx_pkg::resp_okay;
    end else if (araddr[1:0] == 2'b00 && araddr >= lane_rx_pkg::reg_err_base &&
                 araddr < lane_rx_pkg::reg_err_base + 4 * lane_rx_pkg::n_lanes) begin
      rd_data = err_count;
      rd_resp = lane_rx_pkg::resp_okay;
    end
  end

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////
  always_ff @(posedge clk50) begin
    if (!rst_n) begin
      en_q      <= 1'b0;
      aw_hold   <= 1'b0;
      w_hold    <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      clear_req <= 1'b0;
    end else begin
      en_q      <= 1'b1;
      clear_req <= 1'b0;                     // single cycle request
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_go) begin
        bvalid  <= 1'b1;
        aw_hold <= 1'b0;
        w_hold  <= 1'b0;
        if (wr_addr == lane_rx_pkg::reg_ctrl && wr_data[0]) clear_req <= 1'b1;
      end else begin
        if (aw_take) aw_hold <= 1'b1;
        if (w_take) w_hold <= 1'b1;
      end
      if (ar_take) rvalid <= 1'b1;
      else if (rvalid && rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk50) begin
    if (aw_take) waddr_q <= awaddr;
    if (w_take) wdata_q <= wdata;
    if (ar_take) begin
      rdata <= rd_data;                      // counters sampled at the AR handshake
      rresp <= rd_resp;
    end
  end

endmodule

`default_nettype wire

/* lane_rx_top.sv */
`default_nettype none
`timescale 1ns/100ps

module lane_rx_top (
  input  wire                     clk50,
  input  wire                     rst_n,
  input  wire                     raw_valid,
  output logic                    raw_ready,
  input  lane_rx_pkg::lane_id_t   raw_lane,
  input  lane_rx_pkg::lane_word_t raw_data,
  input  lane_rx_pkg::lane_mask_t induce_error,
  input  lane_rx_pkg::lane_mask_t gearbox_slip,
  input  lane_rx_pkg::lane_mask_t reset_done,
  output lane_rx_pkg::lane_mask_t slip_pulse,
  output logic                    locked,
  input  wire                     awvalid,
  output logic                    awready,
  input  lane_rx_pkg::axil_addr_t awaddr,
  input  wire                     wvalid,
  output logic                    wready,
  input  lane_rx_pkg::axil_data_t wdata,
  output logic                    bvalid,
  input  wire                     bready,
  output logic [1:0]              bresp,
  input  wire                     arvalid,
  output logic                    arready,
  input  lane_rx_pkg::axil_addr_t araddr,
  output logic                    rvalid,
  input  wire                     rready,
  output lane_rx_pkg::axil_data_t rdata,
  output logic [1:0]              rresp
);

  logic                    front_valid;      // front to fifo
  logic                    front_ready;
  lane_rx_pkg::lane_beat_t front_beat;
  logic                    chk_valid;        // fifo to checker
  logic                    chk_ready;
  lane_rx_pkg::lane_beat_t chk_beat;
  logic                    clear_req;
  logic                    busy;
  lane_rx_pkg::lane_id_t   rd_lane;
  lane_rx_pkg::count_t     word_count;
  lane_rx_pkg::count_t     err_count;

  lane_word_front u_front (
    .clk50, .rst_n, .raw_valid, .raw_ready, .raw_lane, .raw_data,
    .induce_error, .gearbox_slip, .reset_done,
    .beat_valid (front_valid), .beat_ready (front_ready), .beat (front_beat),
    .slip_pulse, .locked
  );

  lane_word_fifo u_fifo (
    .clk50, .rst_n,
    .in_valid  (front_valid), .in_ready  (front_ready), .in_beat  (front_beat),
    .out_valid (chk_valid),   .out_ready (chk_ready),   .out_beat (chk_beat)
  );

  lane_pattern_checker u_checker (
    .clk50, .rst_n,
    .beat_valid (chk_valid), .beat_ready (chk_ready), .beat (chk_beat),
    .clear_req, .busy, .rd_lane, .word_count, .err_count
  );

  axil_lane_status u_regs (
    .clk50, .rst_n,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .locked, .busy, .clear_req, .rd_lane, .word_count, .err_count
  );

endmodule

`default_nettype wire

/* tb_lane_rx_asserts.sv */
`default_nettype none
`timescale 1ns/100ps

module lane_rx_asserts (
  input  wire                     clk50,
  input  wire                     rst_n,
  input  wire                     front_valid,
  input  wire                     front_ready,
  input  lane_rx_pkg::lane_beat_t front_beat,
  input  wire                     chk_valid,
  input  wire                     chk_ready,
  input  lane_rx_pkg::lane_beat_t chk_beat,
  input  wire                     bvalid,
  input  wire                     bready,
  input  wire                     rvalid,
  input  wire                     rready,
  input  lane_rx_pkg::lane_mask_t slip_pulse
);

  int fail_count = 0;                      // read by the testbench every cycle

  // stream stages hold valid and data until taken
  a_front_hold: assert property (@(posedge clk50) disable iff (!rst_n)
      front_valid && !front_ready |=> front_valid && $stable(front_beat))
    else begin
      fail_count++;
      $error("front beat dropped or changed before ready");
    end

  a_fifo_hold: assert property (@(posedge clk50) disable iff (!rst_n)
      chk_valid && !chk_ready |=> chk_valid && $stable(chk_beat))
    else begin
      fail_count++;
      $error("fifo beat dropped or changed before ready");
    end

  a_bvalid_hold: assert property (@(posedge clk50) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  a_rvalid_hold: assert property (@(posedge clk50) disable iff (!rst_n)
      rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  ////////////////////////////////////////
  // slip strobe is at most two cycles long
  ////////////////////////////////////////
  for (genvar i = 0; i < lane_rx_pkg::n_lanes; i++) begin : g_slip
    a_slip_len: assert property (@(posedge clk50) disable iff (!rst_n)
        slip_pulse[i] && $past(slip_pulse[i]) |=> !slip_pulse[i])
      else begin
        fail_count++;
        $error("slip_pulse high for more than two cycles on lane %0d", i);
      end
  end

endmodule

`default_nettype wire

/* tb_lane_rx.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_lane_rx;

  logic                    clk50;
  logic                    rst_n;
  logic                    raw_valid;
  logic                    raw_ready;
  lane_rx_pkg::lane_id_t   raw_lane;
  lane_rx_pkg::lane_word_t raw_data;
  lane_rx_pkg::lane_mask_t induce_error;
  lane_rx_pkg::lane_mask_t gearbox_slip;
  lane_rx_pkg::lane_mask_t reset_done;
  lane_rx_pkg::lane_mask_t slip_pulse;
  logic                    locked;
  logic                    awvalid;
  logic                    awready;
  lane_rx_pkg::axil_addr_t awaddr;
  logic                    wvalid;
  logic                    wready;
  lane_rx_pkg::axil_data_t wdata;
  logic                    bvalid;
  logic                    bready;
  logic [1:0]              bresp;
  logic                    arvalid;
  logic                    arready;
  lane_rx_pkg::axil_addr_t araddr;
  logic                    rvalid;
  logic                    rready;
  lane_rx_pkg::axil_data_t rdata;
  logic [1:0]              rresp;

  logic [15:0]             lfsr;          // stimulus generator state
  lane_rx_pkg::count_t     exp_words [lane_rx_pkg::n_lanes]; // predicted counters
  lane_rx_pkg::count_t     exp_errs  [lane_rx_pkg::n_lanes];
  logic [31:0]             d;
  logic [1:0]              r;
  logic [31:0]             v;
  lane_rx_pkg::lane_mask_t mask;
  int                      n;

  lane_rx_top UUT (.*);

  bind lane_rx_top lane_rx_asserts u_asserts (
    .clk50, .rst_n, .front_valid, .front_ready, .front_beat,
    .chk_valid, .chk_ready, .chk_beat, .bvalid, .bready, .rvalid, .rready, .slip_pulse
  );

  initial begin
    clk50 = 1'b0;
    forever #10 clk50 = ~clk50;            // 50 MHz
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic end_in_failure(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end_in_failure("value mismatch");
    end
  endtask

  // bound assertions end the run as soon as one fires
  always @(posedge clk50) begin
    if (UUT.u_asserts.fail_count != 0) end_in_failure("a bound assertion failed");
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int nb, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nb; i++) begin
      lfsr = lfsr_step(lfsr);              // one step per bit
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic tick();
    @(posedge clk50);
    #2;                                    // drive and sample point
  endtask

  // raw word whose reversed form repeats p in every group
  function automatic lane_rx_pkg::lane_word_t good_raw_word(input logic [31:0] p);
    lane_rx_pkg::lane_word_t rev;
    lane_rx_pkg::lane_word_t raw;
    rev = {(lane_rx_pkg::word_w / 32){p}};
    for (int i = 0; i < lane_rx_pkg::word_w; i++) raw[i] = rev[lane_rx_pkg::word_w-1-i];
    return raw;
  endfunction

  // reference model of the receive path for one word
  function automatic logic predict_error(input lane_rx_pkg::lane_word_t raw, input logic inject);
    lane_rx_pkg::lane_word_t w;
    logic                    bad;
    w = raw;
    if (inject) w[lane_rx_pkg::err_bit] = ~w[lane_rx_pkg::err_bit];
    bad = 1'b0;
    for (int i = 32; i < lane_rx_pkg::word_w; i++) begin
      if (w[lane_rx_pkg::word_w-1-i] != w[lane_rx_pkg::word_w-1-(i % 32)]) bad = 1'b1;
    end
    return bad;
  endfunction

  ////////////////////////////////////////
  // raw stream and AXI4-Lite
  ////////////////////////////////////////
  task automatic send_beat(input lane_rx_pkg::lane_id_t lane, input lane_rx_pkg::lane_word_t data);
    int t;
    raw_valid = 1'b1;
    raw_lane  = lane;
    raw_data  = data;
    t = 0;
    while (!raw_ready) begin               // back-pressure from the fifo
      tick();
      t++;
      if (t > 100) end_in_failure("raw_ready stayed low, beat never accepted");
    end
    tick();
    raw_valid = 1'b0;
    exp_words[lane] = exp_words[lane] + 1'b1;
    if (predict_error(data, induce_error[lane])) exp_errs[lane] = exp_errs[lane] + 1'b1;
  endtask

  task automatic send_random(input int count);
    logic [31:0] rv;
    logic [31:0] p;
    for (int k = 0; k < count; k++) begin
      rand_bits(4, rv);
      rand_bits(32, p);
      send_beat(lane_rx_pkg::lane_id_t'(rv % lane_rx_pkg::n_lanes), good_raw_word(p));
      rand_bits(2, rv);
      for (int g = 0; g < rv; g++) tick(); // stall gap
    end
  endtask

  task automatic axi_write(input lane_rx_pkg::axil_addr_t addr, input lane_rx_pkg::axil_data_t data);
    logic aw_hit;
    logic w_hit;
    int   t;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    bready  = 1'b1;
    t = 0;
    while (awvalid || wvalid) begin
      aw_hit = awvalid && awready;
      w_hit  = wvalid && wready;
      tick();
      if (aw_hit) awvalid = 1'b0;
      if (w_hit) wvalid = 1'b0;
      t++;
      if (t > 50) end_in_failure("AXI write address or data never accepted");
    end
    t = 0;
    while (!bvalid) begin
      tick();
      t++;
      if (t > 50) end_in_failure("no AXI write response");
    end
    check_value("bresp", bresp, lane_rx_pkg::resp_okay);
    tick();
    bready = 1'b0;
  endtask

  task automatic axi_read(input lane_rx_pkg::axil_addr_t addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int t;
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b1;
    t = 0;
    while (!arready) begin
      tick();
      t++;
      if (t > 50) end_in_failure("AXI read address never accepted");
    end
    tick();
    arvalid = 1'b0;
    t = 0;
    while (!rvalid) begin
      tick();
      t++;
      if (t > 50) end_in_failure("no AXI read data");
    end
    data = rdata;
    resp = rresp;
    tick();                                // rready high, beat taken here
    rready = 1'b0;
  endtask

  // compare process, polls each word count while the pipeline drains
  task automatic compare_all();
    logic [31:0] cd;
    logic [1:0]  cr;
    int          t;
    for (int ln = 0; ln < lane_rx_pkg::n_lanes; ln++) begin
      axi_read(lane_rx_pkg::axil_addr_t'(lane_rx_pkg::reg_word_base + 4 * ln), cd, cr);
      t = 0;
      while (cd != exp_words[ln] && t < 40) begin
        axi_read(lane_rx_pkg::axil_addr_t'(lane_rx_pkg::reg_word_base + 4 * ln), cd, cr);
        t++;
      end
      check_value($sformatf("word_count[%0d]", ln), cd, exp_words[ln]);
      check_value("rresp", cr, lane_rx_pkg::resp_okay);
      axi_read(lane_rx_pkg::axil_addr_t'(lane_rx_pkg::reg_err_base + 4 * ln), cd, cr);
      check_value($sformatf("err_count[%0d]", ln), cd, exp_errs[ln]);
    end
  endtask

  task automatic wait_clear_done();
    logic [31:0] sd;
    logic [1:0]  sr;
    int          t;
    axi_read(lane_rx_pkg::reg_status, sd, sr);
    check_value("busy", sd[1], 1'b1);      // sweep still running
    t = 0;
    while (sd[1]) begin
      axi_read(lane_rx_pkg::reg_status, sd, sr);
      t++;
      if (t > 40) end_in_failure("clear never finished, busy stayed high");
    end
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////
  initial begin
    lfsr         = 16'd35884;
    rst_n        = 1'b0;
    raw_valid    = 1'b0;
    raw_lane     = '0;
    raw_data     = '0;
    induce_error = '0;
    gearbox_slip = '0;
    reset_done   = '0;
    awvalid      = 1'b0;
    awaddr       = '0;
    wvalid       = 1'b0;
    wdata        = '0;
    bready       = 1'b0;
    arvalid      = 1'b0;
    araddr       = '0;
    rready       = 1'b0;
    for (int i = 0; i < lane_rx_pkg::n_lanes; i++) begin
      exp_words[i] = '0;
      exp_errs[i]  = '0;
    end
    repeat (4) @(posedge clk50);
    #2;
    rst_n = 1'b1;

    // counters clear and lock follows reset_done
    check_value("locked", locked, 1'b0);
    axi_read(lane_rx_pkg::reg_status, d, r);
    check_value("status", d, 32'h0);
    compare_all();
    reset_done = '1;
    n = 0;
    while (!locked) begin
      tick();
      n++;
      if (n > 10) end_in_failure("locked never rose with all lanes reset done");
    end
    axi_read(lane_rx_pkg::reg_status, d, r);
    check_value("status.locked", d[0], 1'b1);

    // unmapped addresses
    axi_read(8'h3c, d, r);
    check_value("rresp", r, lane_rx_pkg::resp_slverr);
    check_value("rdata", d, 32'h0);
    axi_read(8'hc0, d, r);
    check_value("rresp", r, lane_rx_pkg::resp_slverr);

    // clean traffic
    send_random(60);
    compare_all();

    // error injection on a subset of lanes
    rand_bits(12, v);
    mask = v[11:0];
    if (mask == '0) mask[0] = 1'b1;
    if (&mask) mask[11] = 1'b0;            // keep one lane clean
    induce_error = mask;
    send_random(60);
    induce_error = '0;
    compare_all();

    // slip strobe on one lane, level then held
    rand_bits(4, v);
    mask = '0;
    mask[v % lane_rx_pkg::n_lanes] = 1'b1;
    gearbox_slip = mask;
    for (int k = 0; k < 8; k++) begin
      check_value("slip_pulse", slip_pulse, (k == 1 || k == 2) ? 32'(mask) : 32'h0);
      tick();
    end
    gearbox_slip = '0;

    // sweeping clear with traffic arriving during it
    axi_write(lane_rx_pkg::reg_ctrl, 32'h1);
    for (int i = 0; i < lane_rx_pkg::n_lanes; i++) begin
      exp_words[i] = '0;
      exp_errs[i]  = '0;
    end
    fork
      send_random(30);
      wait_clear_done();
    join
    compare_all();

    if (UUT.u_asserts.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
lane_rx_pkg.sv
lane_word_front.sv
lane_word_fifo.sv
lane_pattern_checker.sv
axil_lane_status.sv
lane_rx_top.sv
tb_lane_rx_asserts.sv
tb_lane_rx.sv
